//--- testbench/neuron_stimulus.txt
# Columns: M decay adder model acc | W addr value | L addr value | S name spike potential
# Addresses and values in hex, values Q16.16, L arms a load for the next S, E ends the run
# Weight accumulation
M 1 0 0 1
W 001 00002000
W 002 00004000
W 003 00001000
W 004 FFFFE000
M 1 0 0 0
W 001 00000000
W 001 00000000
W 002 00000000
W 003 00000000
W 004 00000000
S accum_sum 0 00007000
# Leak modes
M 0 1 0 1
W 3FF 00002000
M 2 1 0 1
S leak_half 0 00001000
M 3 1 0 1
S leak_quarter 0 00000C00
M 4 1 0 1
S leak_eighth 0 00000A80
M 5 1 0 1
S linear_stop 0 00000000
M 0 1 0 1
W 3FF FFFF8000
M 5 1 0 1
S linear_neg 0 FFFF9000
# Threshold and reset models
M 0 1 0 1
W 3FF 00000000
M 1 3 0 1
W 3FF 00020000
M 1 2 1 1
W 3FF 00018000
S below_thr 0 00018000
S subtract 1 00010000
M 1 2 0 1
S reset_zero 1 00000000
M 1 2 2 1
S clamp_below 0 00018000
S clamp_fire 1 00000000
W 3FF FFFF0000
S clamp_neg 0 00000000
# Saturation
M 0 1 0 1
W 3FF 70000000
M 1 3 0 1
W 3FF 00010000
M 1 2 1 1
W 3FF 70000000
S sat_max 1 7FFEFFFF
M 0 1 0 1
W 3FF 90000000
M 1 2 0 1
W 3FF 90000000
S sat_min 0 80000000
S sat_min_hold 0 80000000
# Step boundary
M 0 1 0 1
W 3FF 00000000
M 1 0 0 0
W 001 00000000
L 002 00000000
S boundary_now 0 00002000
S boundary_next 0 00006000
E

//--- flist.f
design/neuron_pkg.sv
design/synapse_accumulator.sv
design/potential_decay.sv
design/potential_adder.sv
design/neuron.sv
testbench/neuron_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the neuron testbench with Verilator, run it and check for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f flist.f --top-module neuron_tb \
    -Mdir obj_dir -o neuron_sim || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/neuron_sim)
echo "$sim_out"

echo "$sim_out" | grep -q "^Simulation PASSED$" && exit 0 || exit 1

//--- testbench/neuron_tb.sv
`timescale 1ns/1ps
`default_nettype none

module neuron_tb;
    import neuron_pkg::*;

    localparam int ADDR_WIDTH = 10;
    localparam int MAX_WAIT   = 10;     // Cycles allowed from time_step to done
    localparam int MAX_CMDS   = 1000;

    logic                  clk;
    logic                  rst_n;
    logic                  time_step;
    logic                  load;
    logic [ADDR_WIDTH-1:0] address;
    weight_t               value;
    logic [2:0]            decay_mode;
    logic [2:0]            adder_mode;
    logic [1:0]            reset_model;
    logic                  acc_mode;
    logic                  spike;
    potential_t            potential;

    int                    fd;
    int                    steps_run;
    int                    spike_errors;
    int                    pot_errors;
    int                    other_errors;
    logic                  armed;       // Load that rides with the next time_step
    logic [ADDR_WIDTH-1:0] armed_addr;
    weight_t               armed_value;

    neuron UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .time_step  (time_step),
        .load       (load),
        .address    (address),
        .value      (value),
        .decay_mode (decay_mode),
        .adder_mode (adder_mode),
        .reset_model(reset_model),
        .acc_mode   (acc_mode),
        .spike      (spike),
        .potential  (potential)
    );

    always #2 clk = ~clk;

    // Drive helpers ------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_load(input logic [ADDR_WIDTH-1:0] addr, input weight_t data);
        load    = 1'b1;
        address = addr;
        value   = data;
        next_cycle();
        load = 1'b0;
    endtask

    task automatic run_step(input logic [8*32-1:0] name, input int exp_spike,
                            input potential_t exp_pot);
        int waited;

        next_cycle();                   // Last spike strobe then falls in T-2
        time_step = 1'b1;
        if (armed) begin
            load    = 1'b1;
            address = armed_addr;
            value   = armed_value;
        end
        next_cycle();
        time_step = 1'b0;
        load      = 1'b0;
        armed     = 1'b0;
        waited    = 0;
        while (!UUT.done && waited < MAX_WAIT) begin
            next_cycle();
            waited++;
        end
        steps_run++;
        if (!UUT.done) begin
            $display("Step %0s did not finish within %0d cycles, no spike result was seen",
                     name, MAX_WAIT);
            other_errors++;
        end else begin
            if (spike !== exp_spike[0]) begin
                $display("Error %0s spike: expected %0d, actual %0d", name, exp_spike, spike);
                spike_errors++;
            end
            next_cycle();               // New potential shows from T+3
            if (potential !== exp_pot) begin
                $display("Error %0s potential: expected %h, actual %h",
                         name, exp_pot, potential);
                pot_errors++;
            end
        end
    endtask

    // Stimulus file ------------------------------
    task automatic read_commands();
        logic [7:0]      cmd;
        logic [8*32-1:0] name;
        logic [8*96-1:0] rest;
        logic [31:0]     hex_a;
        logic [31:0]     hex_b;
        int              f_a;
        int              f_b;
        int              f_c;
        int              f_d;
        int              code;
        int              count;
        logic            finished;

        finished = 1'b0;
        count    = 0;
        while (!finished && count < MAX_CMDS) begin
            count++;
            code = $fscanf(fd, " %c", cmd);
            if (code != 1) begin
                $display("Stimulus file ended before the E command");
                other_errors++;
                finished = 1'b1;
            end else if (cmd == "#") begin
                code = $fgets(rest, fd);    // Comment line
            end else if (cmd == "M") begin
                code = $fscanf(fd, "%d %d %d %d", f_a, f_b, f_c, f_d);
                decay_mode  = f_a[2:0];
                adder_mode  = f_b[2:0];
                reset_model = f_c[1:0];
                acc_mode    = f_d[0];
            end else if (cmd == "W") begin
                code = $fscanf(fd, "%h %h", hex_a, hex_b);
                apply_load(hex_a[ADDR_WIDTH-1:0], hex_b);
            end else if (cmd == "L") begin
                code = $fscanf(fd, "%h %h", hex_a, hex_b);
                armed       = 1'b1;
                armed_addr  = hex_a[ADDR_WIDTH-1:0];
                armed_value = hex_b;
            end else if (cmd == "S") begin
                code = $fscanf(fd, "%s %d %h", name, f_a, hex_a);
                if (code != 3) begin
                    $display("Step line in the stimulus file is malformed");
                    other_errors++;
                    finished = 1'b1;
                end else begin
                    run_step(name, f_a, hex_a);
                end
            end else if (cmd == "E") begin
                finished = 1'b1;
            end else begin
                $display("Unknown stimulus command %c", cmd);
                other_errors++;
                finished = 1'b1;
            end
        end
        if (!finished) begin
            $display("Stimulus file has too many lines without reaching E");
            other_errors++;
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        time_step    = 1'b0;
        load         = 1'b0;
        address      = '0;
        value        = '0;
        decay_mode   = DECAY_NONE;
        adder_mode   = ADD_ACCUM;
        reset_model  = MODEL_RESET_ZERO;
        acc_mode     = 1'b1;
        armed        = 1'b0;
        armed_addr   = '0;
        armed_value  = '0;
        steps_run    = 0;
        spike_errors = 0;
        pot_errors   = 0;
        other_errors = 0;
        repeat (3) next_cycle();
        rst_n = 1'b1;

        fd = $fopen("testbench/neuron_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file testbench/neuron_stimulus.txt");
            other_errors++;
        end else begin
            read_commands();
            $fclose(fd);
        end

        $display("Steps %0d, spike errors %0d, potential errors %0d, other errors %0d",
                 steps_run, spike_errors, pot_errors, other_errors);
        if (spike_errors + pot_errors + other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/neuron.sv
`timescale 1ns/1ps
`default_nettype none

module neuron #(
    parameter int                     ADDR_WIDTH = 10,
    parameter neuron_pkg::potential_t LEAK_STEP  = 32'sd4096
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   time_step,
    input  logic                   load,
    input  logic [ADDR_WIDTH-1:0]  address,
    input  neuron_pkg::weight_t    value,
    input  logic [2:0]             decay_mode,
    input  logic [2:0]             adder_mode,
    input  logic [1:0]             reset_model,
    input  logic                   acc_mode,
    output logic                   spike,
    output neuron_pkg::potential_t potential
);
    import neuron_pkg::*;

    weight_t    accumulated_out;
    logic       acc_ready;
    potential_t decayed_potential;
    logic       decay_ready;
    potential_t final_potential;
    logic       done;

    // Parallel stages ------------------------------
    synapse_accumulator #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) acc (
        .clk            (clk),
        .rst_n          (rst_n),
        .time_step      (time_step),
        .load           (load),
        .mode           (acc_mode),
        .address        (address),
        .value          (value),
        .accumulated_out(accumulated_out),
        .acc_ready      (acc_ready)
    );

    potential_decay #(
        .LEAK_STEP(LEAK_STEP)
    ) decay (
        .clk              (clk),
        .rst_n            (rst_n),
        .time_step        (time_step),
        .load             (load),
        .mode             (decay_mode),
        .value            (value),
        .final_potential  (final_potential),
        .done             (done),
        .decayed_potential(decayed_potential),
        .decay_ready      (decay_ready),
        .potential        (potential)
    );

    // Combining stage, result goes back to the decay unit
    potential_adder adder (
        .clk              (clk),
        .rst_n            (rst_n),
        .load             (load),
        .mode             (adder_mode),
        .reset_model      (reset_model),
        .value            (value),
        .accumulated_out  (accumulated_out),
        .acc_ready        (acc_ready),
        .decayed_potential(decayed_potential),
        .decay_ready      (decay_ready),
        .final_potential  (final_potential),
        .done             (done),
        .spike            (spike)
    );

endmodule

`default_nettype wire

//--- design/potential_adder.sv
`timescale 1ns/1ps
`default_nettype none

module potential_adder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load,
    input  logic [2:0]             mode,
    input  logic [1:0]             reset_model,
    input  neuron_pkg::weight_t    value,
    input  neuron_pkg::weight_t    accumulated_out,
    input  logic                   acc_ready,
    input  neuron_pkg::potential_t decayed_potential,
    input  logic                   decay_ready,
    output neuron_pkg::potential_t final_potential,
    output logic                   done,
    output logic                   spike
);
    import neuron_pkg::*;

    potential_t         threshold;
    weight_t            direct_current;   // Held until the next direct load
    weight_t            current;
    logic               need_acc;
    logic               go;
    logic signed [32:0] sum_wide;
    potential_t         sum;
    logic signed [32:0] sub_wide;
    logic               fire;
    potential_t         result;

    // Configuration registers ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            threshold      <= THRESHOLD_DEFAULT;
            direct_current <= '0;
        end else if (load) begin
            if (mode == ADD_THRESHOLD) begin
                threshold <= value;
            end else if (mode == ADD_DIRECT) begin
                direct_current <= value;
            end
        end
    end

    // Strobe join
    assign need_acc = (mode == ADD_ACCUM);
    assign go       = decay_ready && (acc_ready || !need_acc);

    // Sum, threshold test and reset model ------------------------------
    always_comb begin
        case (mode)
            ADD_ACCUM:  current = accumulated_out;
            ADD_DIRECT: current = direct_current;
            default:    current = 32'sd0;   // Idle and threshold load
        endcase

        sum_wide = decayed_potential + current;
        sum      = sat32(sum_wide);
        fire     = (sum >= threshold);
        sub_wide = sum - threshold;

        if (fire) begin
            case (reset_model)
                MODEL_SUBTRACT:   result = sat32(sub_wide);
                MODEL_RESET_ZERO: result = '0;
                MODEL_CLAMP:      result = '0;
                default:          result = '0;
            endcase
        end else if (reset_model == MODEL_CLAMP && sum < 0) begin
            result = '0;    // No negative potential
        end else begin
            result = sum;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done  <= 1'b0;
            spike <= 1'b0;
        end else begin
            done  <= go;
            spike <= go && fire;
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            final_potential <= result;
        end
    end

endmodule

`default_nettype wire

//--- design/potential_decay.sv
`timescale 1ns/1ps
`default_nettype none

module potential_decay #(
    parameter neuron_pkg::potential_t LEAK_STEP = 32'sd4096   // 0.0625
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   time_step,
    input  logic                   load,
    input  logic [2:0]             mode,
    input  neuron_pkg::weight_t    value,
    input  neuron_pkg::potential_t final_potential,
    input  logic                   done,
    output neuron_pkg::potential_t decayed_potential,
    output logic                   decay_ready,
    output neuron_pkg::potential_t potential
);
    import neuron_pkg::*;

    potential_t pot;     // Membrane potential
    potential_t leaked;

    assign potential = pot;

    // Leak selection ------------------------------
    always_comb begin
        case (mode)
            DECAY_HALF:    leaked = pot - (pot >>> 1);
            DECAY_QUARTER: leaked = pot - (pot >>> 2);
            DECAY_EIGHTH:  leaked = pot - (pot >>> 3);
            DECAY_LINEAR: begin
                // Step toward zero, never past it
                if (pot > LEAK_STEP) begin
                    leaked = pot - LEAK_STEP;
                end else if (pot < -LEAK_STEP) begin
                    leaked = pot + LEAK_STEP;
                end else begin
                    leaked = '0;
                end
            end
            DECAY_IDLE, DECAY_NONE: leaked = pot;
            default:                leaked = pot;
        endcase
    end

    // Potential register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pot <= '0;
        end else if (mode == DECAY_IDLE) begin
            if (load) begin
                pot <= value;    // Direct write, adder result ignored
            end
        end else if (done) begin
            pot <= final_potential;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            decay_ready <= 1'b0;
        end else begin
            decay_ready <= time_step;
        end
    end

    always_ff @(posedge clk) begin
        if (time_step) begin
            decayed_potential <= leaked;
        end
    end

endmodule

`default_nettype wire

//--- design/synapse_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module synapse_accumulator #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  time_step,
    input  logic                  load,
    input  logic                  mode,       // 1 configure, 0 run
    input  logic [ADDR_WIDTH-1:0] address,
    input  neuron_pkg::weight_t   value,
    output neuron_pkg::weight_t   accumulated_out,
    output logic                  acc_ready
);
    import neuron_pkg::*;

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    weight_t               mem [DEPTH];
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic                  rd_valid;
    weight_t               rd_weight;
    logic                  add_valid;
    weight_t               running_sum;
    weight_t               addend;
    logic signed [32:0]    sum_wide;
    weight_t               sum_next;

    // Weight memory ------------------------------
    always_ff @(posedge clk) begin
        if (load && mode) begin
            mem[address] <= value;
        end
    end

    // Spike pipeline ------------------------------
    // Stage 1 captures the source, stage 2 reads its weight
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid  <= 1'b0;
            add_valid <= 1'b0;
        end else begin
            rd_valid  <= load && !mode;
            add_valid <= rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load && !mode) begin
            rd_addr <= address;
        end
        rd_weight <= mem[rd_addr];
    end

    // Add stage
    always_comb begin
        addend   = add_valid ? rd_weight : 32'sd0;
        sum_wide = running_sum + addend;
        sum_next = sat32(sum_wide);
    end

    // Sum closes on time_step, including the add finishing this cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running_sum     <= '0;
            accumulated_out <= '0;
            acc_ready       <= 1'b0;
        end else begin
            acc_ready <= time_step;
            if (time_step) begin
                accumulated_out <= sum_next;
                running_sum     <= '0;
            end else begin
                running_sum <= sum_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/neuron_pkg.sv
`default_nettype none

package neuron_pkg;

    // Q16.16 signed fixed point
    typedef logic signed [31:0] potential_t;
    typedef logic signed [31:0] weight_t;

    // Decay mode codes
    localparam logic [2:0] DECAY_IDLE    = 3'd0;
    localparam logic [2:0] DECAY_NONE    = 3'd1;
    localparam logic [2:0] DECAY_HALF    = 3'd2;
    localparam logic [2:0] DECAY_QUARTER = 3'd3;
    localparam logic [2:0] DECAY_EIGHTH  = 3'd4;
    localparam logic [2:0] DECAY_LINEAR  = 3'd5;

    // Adder input mode codes
    localparam logic [2:0] ADD_ACCUM     = 3'd0;
    localparam logic [2:0] ADD_IDLE      = 3'd1;
    localparam logic [2:0] ADD_DIRECT    = 3'd2;
    localparam logic [2:0] ADD_THRESHOLD = 3'd3;

    // Reset model codes
    localparam logic [1:0] MODEL_RESET_ZERO = 2'd0;
    localparam logic [1:0] MODEL_SUBTRACT   = 2'd1;
    localparam logic [1:0] MODEL_CLAMP      = 2'd2;

    localparam potential_t POT_MAX           = 32'sh7fff_ffff;
    localparam potential_t POT_MIN           = 32'sh8000_0000;
    localparam potential_t THRESHOLD_DEFAULT = 32'sd65536;   // 1.0

    // Clamp a 33-bit intermediate back into 32 bits
    function automatic potential_t sat32(input logic signed [32:0] x);
        if (x > POT_MAX) return POT_MAX;
        if (x < POT_MIN) return POT_MIN;
        return x[31:0];
    endfunction

endpackage

`default_nettype wire
